/* gpio_apb_regs.sv */
`timescale 1ns/1ps
`include "gpio_consts.svh"

module gpio_apb_regs
(
   input  logic                 PCLK,
   input  logic                 aresetn,
   input  logic                 psel_i,
   input  logic                 penable_i,
   input  logic                 pwrite_i,
   input  gpio_pkg::apb_addr_t  paddr_i,
   input  gpio_pkg::apb_data_t  pwdata_i,
   input  gpio_pkg::pin_vec_t   sync_lvl_i,
   input  gpio_pkg::pin_vec_t   intr_stat_i,
   output gpio_pkg::apb_data_t  prdata_o,
   output logic                 pready_o,
   output logic                 pslverr_o,
   output gpio_pkg::pin_vec_t   gpio_out_o,
   output gpio_pkg::pin_vec_t   gpio_oe_o,
   output gpio_pkg::pin_vec_t   int_en_o,
   output gpio_pkg::int_type_e  int_type_o [`GPIO_NUM],
   output gpio_pkg::pin_vec_t   irq_clr_o
);

   import gpio_pkg::*;

   cfg_byte_t   cfg_q [`GPIO_NUM];
   pin_vec_t    gpout_q;
   pin_vec_t    out_en;
   pin_vec_t    in_en;
   pin_vec_t    oe_en;
   logic        wr_en;
   logic        cfg_sel;
   logic [4:0]  cfg_idx;

   // ----------------------------------------
   // write decode
   // ----------------------------------------
   // no wait states, access phase is always the last
   assign pready_o  = 1'b1;
   assign pslverr_o = 1'b0;

   assign wr_en   = psel_i & penable_i & pwrite_i;
   assign cfg_sel = (paddr_i < `GPIO_CFG_LIMIT);
   // bit 7 is zero inside the config window
   assign cfg_idx = paddr_i[6:2];

   // pin config bytes, upper data bits dropped
   always_ff @(posedge PCLK or negedge aresetn)
   begin
      if (!aresetn)
      begin
         for (int i = 0; i < `GPIO_NUM; i++)
         begin
            cfg_q[i] <= '0;
         end
      end
      else if (wr_en && cfg_sel)
      begin
         cfg_q[cfg_idx] <= pwdata_i[7:0];
      end
   end

   // output data register
   always_ff @(posedge PCLK or negedge aresetn)
   begin
      if (!aresetn)
      begin
         gpout_q <= `GPIO_OUT_RESET;
      end
      else if (wr_en && (paddr_i == `GPIO_GPOUT_ADDR))
      begin
         gpout_q <= pwdata_i;
      end
   end

   // ----------------------------------------
   // config fields per pin
   // ----------------------------------------
   always_comb
   begin
      for (int i = 0; i < `GPIO_NUM; i++)
      begin
         out_en[i]     = cfg_q[i][`GPIO_CFG_OUT_EN];
         in_en[i]      = cfg_q[i][`GPIO_CFG_IN_EN];
         oe_en[i]      = cfg_q[i][`GPIO_CFG_OE];
         int_en_o[i]   = cfg_q[i][`GPIO_CFG_INT_EN];
         int_type_o[i] = int_type_e'(cfg_q[i][`GPIO_CFG_TYPE_LSB +: 3]);
      end
   end

   // pins only drive where the output register is enabled
   assign gpio_out_o = gpout_q & out_en;
   assign gpio_oe_o  = oe_en & out_en;

   // write-one-to-clear mask for the interrupt block
   assign irq_clr_o = (wr_en && (paddr_i == `GPIO_INTR_ADDR)) ? pwdata_i : '0;

   // ----------------------------------------
   // read mux
   // ----------------------------------------
   always_comb
   begin
      prdata_o = '0;
      if (psel_i)
      begin
         if (cfg_sel)
         begin
            // zero-extended config byte
            prdata_o = apb_data_t'(cfg_q[cfg_idx]);
         end
         else
         begin
            case (paddr_i)
               `GPIO_INTR_ADDR:  prdata_o = intr_stat_i;
               `GPIO_GPIN_ADDR:  prdata_o = sync_lvl_i & in_en;
               `GPIO_GPOUT_ADDR: prdata_o = gpout_q;
               default:          prdata_o = '0;
            endcase
         end
      end
   end

   // ----------------------------------------
   // checks
   // ----------------------------------------
   // the interrupt block must only see a clear mask on a real clear access
   a_clr_only_on_intr_write: assert property (
      @(posedge PCLK) disable iff (!aresetn)
      !(psel_i && penable_i && pwrite_i && (paddr_i == `GPIO_INTR_ADDR))
         |-> (irq_clr_o == '0)
   );

endmodule

/* gpio_consts.svh */
`ifndef GPIO_CONSTS_SVH
`define GPIO_CONSTS_SVH

// ----------------------------------------
// sizes
// ----------------------------------------
`define GPIO_NUM          32
`define GPIO_DW           32
`define GPIO_AW           8

// ----------------------------------------
// register map, byte addresses
// ----------------------------------------
// config registers sit below this, one word per pin
`define GPIO_CFG_LIMIT    8'h80
`define GPIO_INTR_ADDR    8'h80
`define GPIO_GPIN_ADDR    8'h90
`define GPIO_GPOUT_ADDR   8'hA0

// bit positions inside a pin config byte
`define GPIO_CFG_OUT_EN   0
`define GPIO_CFG_IN_EN    1
`define GPIO_CFG_OE       2
`define GPIO_CFG_INT_EN   3
// 3-bit interrupt type field, bits 7:5
`define GPIO_CFG_TYPE_LSB 5

// output data register after reset
`define GPIO_OUT_RESET    32'h0000_0000

`endif

/* gpio_in_sync.sv */
`timescale 1ns/1ps

module gpio_in_sync
(
   input  logic                PCLK,
   input  logic                aresetn,
   input  gpio_pkg::pin_vec_t  gpio_in_i,
   output gpio_pkg::pin_vec_t  sync_lvl_o,
   output gpio_pkg::pin_vec_t  rise_o,
   output gpio_pkg::pin_vec_t  fall_o
);

   import gpio_pkg::*;

   pin_vec_t gpin1;
   pin_vec_t gpin2;
   pin_vec_t gpin3;

   // ----------------------------------------
   // synchroniser
   // ----------------------------------------
   // two flops for metastability, third for edge compare
   always_ff @(posedge PCLK or negedge aresetn)
   begin
      if (!aresetn)
      begin
         gpin1 <= '0;
         gpin2 <= '0;
         gpin3 <= '0;
      end
      else
      begin
         gpin1 <= gpio_in_i;
         gpin2 <= gpin1;
         gpin3 <= gpin2;
      end
   end

   assign sync_lvl_o = gpin3;

   // one-cycle pulses, seen just before the level updates
   assign rise_o = gpin2 & ~gpin3;
   assign fall_o = ~gpin2 & gpin3;

   // ----------------------------------------
   // checks
   // ----------------------------------------
   a_no_rise_and_fall: assert property (
      @(posedge PCLK) disable iff (!aresetn)
      (rise_o & fall_o) == '0
   );

endmodule

/* gpio_irq.sv */
`timescale 1ns/1ps
`include "gpio_consts.svh"

module gpio_irq
(
   input  logic                 PCLK,
   input  logic                 aresetn,
   input  gpio_pkg::pin_vec_t   sync_lvl_i,
   input  gpio_pkg::pin_vec_t   rise_i,
   input  gpio_pkg::pin_vec_t   fall_i,
   input  gpio_pkg::pin_vec_t   int_en_i,
   input  gpio_pkg::int_type_e  int_type_i [`GPIO_NUM],
   input  gpio_pkg::pin_vec_t   irq_clr_i,
   output gpio_pkg::pin_vec_t   int_o,
   output logic                 int_or_o,
   output gpio_pkg::pin_vec_t   intr_stat_o
);

   import gpio_pkg::*;

   pin_vec_t edge_pos;
   pin_vec_t edge_neg;
   pin_vec_t edge_both;
   pin_vec_t int_pin;
   pin_vec_t intr_q;

   // ----------------------------------------
   // sticky edge flags
   // ----------------------------------------
   // priority per pin
   //   int_en low   -> held at zero
   //   edge seen    -> set, wins over a clear on the same edge
   //   clear bit    -> cleared
   always_ff @(posedge PCLK or negedge aresetn)
   begin
      if (!aresetn)
      begin
         edge_pos  <= '0;
         edge_neg  <= '0;
         edge_both <= '0;
      end
      else
      begin
         edge_pos  <= int_en_i & (rise_i | (edge_pos & ~irq_clr_i));
         edge_neg  <= int_en_i & (fall_i | (edge_neg & ~irq_clr_i));
         edge_both <= int_en_i & (rise_i | fall_i | (edge_both & ~irq_clr_i));
      end
   end

   // ----------------------------------------
   // per-pin source select
   // ----------------------------------------
   always_comb
   begin
      for (int i = 0; i < `GPIO_NUM; i++)
      begin
         case (int_type_i[i])
            INT_LEVEL_HIGH: int_pin[i] = sync_lvl_i[i];
            INT_LEVEL_LOW:  int_pin[i] = ~sync_lvl_i[i];
            INT_EDGE_POS:   int_pin[i] = edge_pos[i];
            INT_EDGE_NEG:   int_pin[i] = edge_neg[i];
            INT_EDGE_BOTH:  int_pin[i] = edge_both[i];
            // codes 5, 6 and 7
            default:        int_pin[i] = 1'b0;
         endcase
      end
   end

   // level types pass straight through, no register in the path
   assign int_o    = int_pin & int_en_i;
   assign int_or_o = |int_o;

   // ----------------------------------------
   // interrupt status register
   // ----------------------------------------
   // cleared bits read zero for one cycle, then track int_o again
   always_ff @(posedge PCLK or negedge aresetn)
   begin
      if (!aresetn)
      begin
         intr_q <= '0;
      end
      else
      begin
         intr_q <= int_o & ~irq_clr_i;
      end
   end

   assign intr_stat_o = intr_q;

   // ----------------------------------------
   // checks
   // ----------------------------------------
   a_int_needs_enable: assert property (
      @(posedge PCLK) disable iff (!aresetn)
      (int_o & ~int_en_i) == '0
   );

endmodule

/* gpio_pkg.sv */
`include "gpio_consts.svh"

package gpio_pkg;

   // one bit per pin
   typedef logic [`GPIO_NUM-1:0] pin_vec_t;

   // APB data and byte address
   typedef logic [`GPIO_DW-1:0] apb_data_t;
   typedef logic [`GPIO_AW-1:0] apb_addr_t;

   // pin configuration register
   //   bit 0    output register enable
   //   bit 1    input enable
   //   bit 2    output enable
   //   bit 3    interrupt enable
   //   bit 7:5  interrupt type
   typedef logic [7:0] cfg_byte_t;

   // interrupt type codes
   // 5 and 6 are unnamed and behave as disabled
   typedef enum logic [2:0]
   {
      INT_LEVEL_HIGH = 3'd0,
      INT_LEVEL_LOW  = 3'd1,
      INT_EDGE_POS   = 3'd2,
      INT_EDGE_NEG   = 3'd3,
      INT_EDGE_BOTH  = 3'd4,
      INT_DISABLED   = 3'd7
   } int_type_e;

endpackage

/* gpio_top.sv */
`timescale 1ns/1ps
`include "gpio_consts.svh"

module gpio_top
(
   input  logic                 PCLK,
   input  logic                 aresetn,
   input  logic                 psel_i,
   input  logic                 penable_i,
   input  logic                 pwrite_i,
   input  gpio_pkg::apb_addr_t  paddr_i,
   input  gpio_pkg::apb_data_t  pwdata_i,
   input  gpio_pkg::pin_vec_t   gpio_in_i,
   output gpio_pkg::apb_data_t  prdata_o,
   output logic                 pready_o,
   output logic                 pslverr_o,
   output gpio_pkg::pin_vec_t   gpio_out_o,
   output gpio_pkg::pin_vec_t   gpio_oe_o,
   output gpio_pkg::pin_vec_t   int_o,
   output logic                 int_or_o
);

   import gpio_pkg::*;

   // synchroniser outputs
   pin_vec_t  sync_lvl;
   pin_vec_t  rise;
   pin_vec_t  fall;

   // register block to interrupt block
   pin_vec_t  int_en;
   int_type_e int_type [`GPIO_NUM];
   pin_vec_t  irq_clr;
   pin_vec_t  intr_stat;

   // ----------------------------------------
   // APB registers and pin outputs
   // ----------------------------------------
   gpio_apb_regs u_regs (
      .PCLK        (PCLK),
      .aresetn     (aresetn),
      .psel_i      (psel_i),
      .penable_i   (penable_i),
      .pwrite_i    (pwrite_i),
      .paddr_i     (paddr_i),
      .pwdata_i    (pwdata_i),
      .sync_lvl_i  (sync_lvl),
      .intr_stat_i (intr_stat),
      .prdata_o    (prdata_o),
      .pready_o    (pready_o),
      .pslverr_o   (pslverr_o),
      .gpio_out_o  (gpio_out_o),
      .gpio_oe_o   (gpio_oe_o),
      .int_en_o    (int_en),
      .int_type_o  (int_type),
      .irq_clr_o   (irq_clr)
   );

   // input pins into the PCLK domain
   gpio_in_sync u_sync (
      .PCLK       (PCLK),
      .aresetn    (aresetn),
      .gpio_in_i  (gpio_in_i),
      .sync_lvl_o (sync_lvl),
      .rise_o     (rise),
      .fall_o     (fall)
   );

   // ----------------------------------------
   // interrupts
   // ----------------------------------------
   gpio_irq u_irq (
      .PCLK        (PCLK),
      .aresetn     (aresetn),
      .sync_lvl_i  (sync_lvl),
      .rise_i      (rise),
      .fall_i      (fall),
      .int_en_i    (int_en),
      .int_type_i  (int_type),
      .irq_clr_i   (irq_clr),
      .int_o       (int_o),
      .int_or_o    (int_or_o),
      .intr_stat_o (intr_stat)
   );

endmodule

/* project.f */
+incdir+.
gpio_pkg.sv
gpio_apb_regs.sv
gpio_in_sync.sv
gpio_irq.sv
gpio_top.sv
tb_gpio.sv

/* tb_gpio.sv */
`timescale 1ns/1ps
`include "gpio_consts.svh"

module tb_gpio;

   import gpio_pkg::*;

   // reset 35, config 66, output 34, input 33, level 65, edge 37
   localparam int APB_TRANSACTIONS = 270;

   logic      PCLK;
   logic      aresetn;
   logic      psel_i;
   logic      penable_i;
   logic      pwrite_i;
   apb_addr_t paddr_i;
   apb_data_t pwdata_i;
   pin_vec_t  gpio_in_i;
   apb_data_t prdata_o;
   logic      pready_o;
   logic      pslverr_o;
   pin_vec_t  gpio_out_o;
   pin_vec_t  gpio_oe_o;
   pin_vec_t  int_o;
   logic      int_or_o;

   // expected copy of the config registers
   cfg_byte_t cfg_mem [`GPIO_NUM];
   int        seed = 32'hfa7d;
   int        err_cnt;
   int        pass_cnt;
   int        fail_cnt;

   gpio_top u_gpio_top (
      .PCLK       (PCLK),
      .aresetn    (aresetn),
      .psel_i     (psel_i),
      .penable_i  (penable_i),
      .pwrite_i   (pwrite_i),
      .paddr_i    (paddr_i),
      .pwdata_i   (pwdata_i),
      .gpio_in_i  (gpio_in_i),
      .prdata_o   (prdata_o),
      .pready_o   (pready_o),
      .pslverr_o  (pslverr_o),
      .gpio_out_o (gpio_out_o),
      .gpio_oe_o  (gpio_oe_o),
      .int_o      (int_o),
      .int_or_o   (int_or_o)
   );

   always #50 PCLK = ~PCLK;

   // ----------------------------------------
   // APB and helpers
   // ----------------------------------------
   // setup phase, access phase, data taken mid access phase
   task automatic apb_access(input logic wr, input apb_addr_t addr, input apb_data_t wdata,
                             output apb_data_t rdata);
      @(posedge PCLK);
      psel_i    <= 1'b1;
      penable_i <= 1'b0;
      pwrite_i  <= wr;
      paddr_i   <= addr;
      pwdata_i  <= wdata;
      @(posedge PCLK);
      penable_i <= 1'b1;
      @(negedge PCLK);
      while (!pready_o)
      begin
         @(negedge PCLK);
      end
      rdata = prdata_o;
      check_value("pslverr_o in access phase", pslverr_o, '0);
      @(posedge PCLK);
      psel_i    <= 1'b0;
      penable_i <= 1'b0;
      pwrite_i  <= 1'b0;
   endtask

   task automatic apb_write(input apb_addr_t addr, input apb_data_t data);
      apb_data_t unused;
      apb_access(1'b1, addr, data, unused);
   endtask

   task automatic apb_read(input apb_addr_t addr, output apb_data_t data);
      apb_access(1'b0, addr, '0, data);
   endtask

   // idle cycles, then stop mid cycle where outputs are stable
   task automatic settle(input int n);
      repeat (n) @(posedge PCLK);
      @(negedge PCLK);
   endtask

   task automatic check_value(input string what, input apb_data_t got, input apb_data_t exp);
      assert (got === exp)
      else
      begin
         $display("ERR %0t ns: %s, got %h expected %h", $time, what, got, exp);
         err_cnt++;
      end
   endtask

   task automatic report_test(input string name, input int errs_at_start);
      if (err_cnt == errs_at_start)
      begin
         pass_cnt++;
         $display("test %s: ok", name);
      end
      else
      begin
         fail_cnt++;
         $display("test %s: failed with %0d errors", name, err_cnt - errs_at_start);
      end
   endtask

   task automatic write_cfg(input int pin, input apb_data_t value);
      cfg_mem[pin] = value[7:0];
      apb_write(apb_addr_t'(pin * 4), value);
   endtask

   task automatic drive_pins(input pin_vec_t value);
      @(posedge PCLK);
      gpio_in_i <= value;
   endtask

   function automatic cfg_byte_t make_cfg(input logic [2:0] code, input logic int_en);
      return (cfg_byte_t'(code) << `GPIO_CFG_TYPE_LSB) | (cfg_byte_t'(int_en) << `GPIO_CFG_INT_EN);
   endfunction

   // one config bit of every pin gathered into a vector
   function automatic pin_vec_t cfg_mask(input int pos);
      pin_vec_t m;
      for (int i = 0; i < `GPIO_NUM; i++)
      begin
         m[i] = cfg_mem[i][pos];
      end
      return m;
   endfunction

   // enabled pins of one interrupt type
   function automatic pin_vec_t type_mask(input int_type_e t);
      pin_vec_t m;
      for (int i = 0; i < `GPIO_NUM; i++)
      begin
         m[i] = (cfg_mem[i][`GPIO_CFG_TYPE_LSB +: 3] == t) && cfg_mem[i][`GPIO_CFG_INT_EN];
      end
      return m;
   endfunction

   // ----------------------------------------
   // tests
   // ----------------------------------------
   task automatic test_reset_state();
      int        errs;
      apb_data_t rd;
      errs = err_cnt;
      for (int i = 0; i < `GPIO_NUM; i++)
      begin
         apb_read(apb_addr_t'(i * 4), rd);
         check_value("config after reset", rd, '0);
      end
      apb_read(`GPIO_INTR_ADDR, rd);
      check_value("interrupt after reset", rd, '0);
      apb_read(`GPIO_GPIN_ADDR, rd);
      check_value("input after reset", rd, '0);
      apb_read(`GPIO_GPOUT_ADDR, rd);
      check_value("output after reset", rd, '0);
      settle(1);
      check_value("gpio_out_o after reset", gpio_out_o, '0);
      check_value("gpio_oe_o after reset", gpio_oe_o, '0);
      check_value("int_o after reset", int_o, '0);
      check_value("int_or_o after reset", int_or_o, '0);
      report_test("reset_state", errs);
   endtask

   task automatic test_config_rw();
      int        errs;
      apb_data_t rd;
      errs = err_cnt;
      // upper data bits are random too and must be dropped
      for (int i = 0; i < `GPIO_NUM; i++)
      begin
         write_cfg(i, $random(seed));
      end
      for (int i = 0; i < `GPIO_NUM; i++)
      begin
         apb_read(apb_addr_t'(i * 4), rd);
         check_value("config readback", rd, apb_data_t'(cfg_mem[i]));
      end
      apb_read(8'h84, rd);
      check_value("unmapped 0x84", rd, '0);
      apb_read(8'hB0, rd);
      check_value("unmapped 0xB0", rd, '0);
      report_test("config_rw", errs);
   endtask

   task automatic test_output_path();
      int        errs;
      apb_data_t data;
      apb_data_t rd;
      pin_vec_t  en;
      errs = err_cnt;
      data = $random(seed);
      for (int i = 0; i < `GPIO_NUM; i++)
      begin
         write_cfg(i, $random(seed));
      end
      apb_write(`GPIO_GPOUT_ADDR, data);
      settle(4);
      en = cfg_mask(`GPIO_CFG_OUT_EN);
      check_value("gpio_out_o gating", gpio_out_o, data & en);
      check_value("gpio_oe_o gating", gpio_oe_o, cfg_mask(`GPIO_CFG_OE) & en);
      apb_read(`GPIO_GPOUT_ADDR, rd);
      check_value("output readback", rd, data);
      report_test("output_path", errs);
   endtask

   task automatic test_input_readback();
      int        errs;
      pin_vec_t  pins;
      apb_data_t rd;
      errs = err_cnt;
      pins = $random(seed);
      for (int i = 0; i < `GPIO_NUM; i++)
      begin
         write_cfg(i, $random(seed));
      end
      drive_pins(pins);
      settle(4);
      apb_read(`GPIO_GPIN_ADDR, rd);
      check_value("input readback", rd, pins & cfg_mask(`GPIO_CFG_IN_EN));
      report_test("input_readback", errs);
   endtask

   task automatic test_level_irq();
      int        errs;
      apb_data_t r;
      apb_data_t rd;
      pin_vec_t  pins;
      pin_vec_t  exp;
      errs = err_cnt;
      for (int i = 0; i < `GPIO_NUM; i++)
      begin
         r = $random(seed);
         write_cfg(i, make_cfg(r[0] ? INT_LEVEL_LOW : INT_LEVEL_HIGH, 1'b1));
      end
      pins = $random(seed);
      drive_pins(pins);
      settle(4);
      exp = (pins & type_mask(INT_LEVEL_HIGH)) | (~pins & type_mask(INT_LEVEL_LOW));
      check_value("level int_o", int_o, exp);
      check_value("level int_or_o", int_or_o, |exp);
      apb_read(`GPIO_INTR_ADDR, rd);
      check_value("level status at 0x80", rd, exp);
      // drop the interrupt enables, keep the types
      for (int i = 0; i < `GPIO_NUM; i++)
      begin
         write_cfg(i, cfg_mem[i] & ~(8'd1 << `GPIO_CFG_INT_EN));
      end
      settle(4);
      check_value("int_o with enables off", int_o, '0);
      check_value("int_or_o with enables off", int_or_o, 1'b0);
      report_test("level_irq", errs);
   endtask

   // move the pins and check which sticky flags came up
   task automatic toggle_and_check(input pin_vec_t from, input pin_vec_t to,
                                   output pin_vec_t exp);
      pin_vec_t  rose;
      pin_vec_t  fell;
      apb_data_t rd;
      rose = to & ~from;
      fell = from & ~to;
      exp  = (rose & type_mask(INT_EDGE_POS)) | (fell & type_mask(INT_EDGE_NEG))
             | ((rose | fell) & type_mask(INT_EDGE_BOTH));
      drive_pins(to);
      settle(4);
      check_value("edge flags on int_o", int_o, exp);
      check_value("edge int_or_o", int_or_o, |exp);
      apb_read(`GPIO_INTR_ADDR, rd);
      check_value("edge flags at 0x80", rd, exp);
   endtask

   task automatic test_edge_irq();
      int          errs;
      logic [2:0]  code;
      pin_vec_t    idle_lvl;
      pin_vec_t    next_lvl;
      pin_vec_t    exp;
      apb_data_t   clr;
      apb_data_t   rd;
      errs = err_cnt;
      idle_lvl = $random(seed);
      next_lvl = $random(seed);
      drive_pins(idle_lvl);
      settle(4);
      // pos, neg, both, then one of the disabled codes 5 to 7
      for (int i = 0; i < `GPIO_NUM; i++)
      begin
         case (i % 4)
            0:       code = INT_EDGE_POS;
            1:       code = INT_EDGE_NEG;
            2:       code = INT_EDGE_BOTH;
            default: code = 3'(5 + (i / 4) % 3);
         endcase
         write_cfg(i, make_cfg(code, 1'b1));
      end
      settle(4);
      check_value("no flags before toggling", int_o, '0);
      toggle_and_check(idle_lvl, next_lvl, exp);
      apb_write(`GPIO_INTR_ADDR, '1);
      settle(4);
      check_value("flags after full clear", int_o, '0);
      toggle_and_check(next_lvl, idle_lvl, exp);
      // partial clear leaves the other flags alone
      clr = $random(seed);
      apb_write(`GPIO_INTR_ADDR, clr);
      settle(4);
      check_value("flags after partial clear", int_o, exp & ~clr);
      apb_read(`GPIO_INTR_ADDR, rd);
      check_value("0x80 after partial clear", rd, exp & ~clr);
      report_test("edge_irq", errs);
   endtask

   // ----------------------------------------
   // main sequence and watchdog
   // ----------------------------------------
   initial
   begin
      PCLK      = 1'b0;
      aresetn   = 1'b0;
      psel_i    = 1'b0;
      penable_i = 1'b0;
      pwrite_i  = 1'b0;
      paddr_i   = '0;
      pwdata_i  = '0;
      gpio_in_i = '0;
      err_cnt   = 0;
      pass_cnt  = 0;
      fail_cnt  = 0;
      repeat (8) @(posedge PCLK);
      aresetn <= 1'b1;
      settle(2);
      test_reset_state();
      test_config_rw();
      test_output_path();
      test_input_readback();
      test_level_irq();
      test_edge_irq();
      $display("tests passed %0d, failed %0d, errors %0d", pass_cnt, fail_cnt, err_cnt);
      if (fail_cnt == 0 && err_cnt == 0)
      begin
         $display("Simulation finished: PASS");
      end
      else
      begin
         $display("Simulation finished: FAIL");
      end
      $finish;
   end

   initial
   begin
      repeat (APB_TRANSACTIONS * 10 + 2000) @(posedge PCLK);
      $display("timeout: the tests did not complete in %0d clock cycles",
               APB_TRANSACTIONS * 10 + 2000);
      $display("Simulation finished: FAIL");
      $finish;
   end

endmodule
